// File: rv_core_pkg.sv
// ====================
// shared widths, opcodes and full-word constants
// instruction class, retire kind and alu op enums
// ====================

package rv_core_pkg;

    // data and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes of the supported subset
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // system words matched exactly
    localparam logic [31:0] inst_ecall  = 32'h0000_0073;
    localparam logic [31:0] inst_ebreak = 32'h0010_0073;

    // decoder classes, codes follow the older decoder key
    typedef enum logic [2:0] {
        class_i       = 3'b000,
        class_n       = 3'b001,
        class_u       = 3'b010,
        class_r       = 3'b011,
        class_s       = 3'b100,
        class_illegal = 3'b111
    } inst_class_e;

    // what a retire record reports
    typedef enum logic [2:0] {
        kind_reg     = 3'd0,
        kind_store   = 3'd1,
        kind_ecall   = 3'd2,
        kind_halt    = 3'd3,
        kind_illegal = 3'd4
    } retire_kind_e;

    // alu_pass hands operand b (the immediate) straight through
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_sltu = 3'd2,
        alu_sra  = 3'd3,
        alu_and  = 3'd4,
        alu_pass = 3'd5
    } alu_op_e;

endpackage

// File: rv_inst_queue.sv
// ====================
// instruction FIFO with
// one credit pulse per pop
// ====================

module rv_inst_queue import rv_core_pkg::*; #(
    parameter int inst_depth = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  logic [xlen-1:0] push_data,
    input  logic            pop,
    output logic            head_valid,
    output logic [xlen-1:0] head_inst,
    output logic            credit
);

    localparam int ptr_w = (inst_depth > 1) ? $clog2(inst_depth) : 1;
    localparam int cnt_w = $clog2(inst_depth + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(inst_depth - 1);

    // storage, no reset needed
    logic [xlen-1:0]  mem [inst_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // sender never pushes without a credit, so no full check
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // pointers wrap at depth, depth need not be a power of 2
            if (push) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // slot freed -> hand one credit back next cycle
            credit <= pop;
        end
    end

    assign head_valid = (count != '0);
    assign head_inst  = mem[rd_ptr];

endmodule

// File: rv_decode.sv
// ====================
// rv32i subset decoder
// class, alu op, register fields, immediate
// ====================

module rv_decode import rv_core_pkg::*; (
    input  logic [xlen-1:0]       inst,
    output inst_class_e           inst_class,
    output alu_op_e               alu_op,
    output logic [reg_addr_w-1:0] rd_addr,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]       imm,
    output logic [1:0]            store_size
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd_addr    = inst[11:7];
    assign rs2_addr   = inst[24:20];
    // sb, sh, sw sit in funct3[1:0]
    assign store_size = inst[13:12];

    // lui and ebreak read x0
    assign rs1_addr = (opcode == op_lui || inst == inst_ebreak) ? '0 : inst[19:15];

    // system words by full match, the rest by opcode and funct fields
    always_comb begin
        inst_class = class_illegal;
        alu_op     = alu_pass;
        if (inst == inst_ecall || inst == inst_ebreak) begin
            inst_class = class_n;
        end else begin
            case (opcode)
                op_imm: begin
                    inst_class = class_i;
                    case (funct3)
                        3'b000:  alu_op = alu_add;
                        3'b011:  alu_op = alu_sltu;
                        3'b111:  alu_op = alu_and;
                        // srai only, srli and slli are not in the subset
                        3'b101:  alu_op = alu_sra;
                        default: inst_class = class_illegal;
                    endcase
                    if (funct3 == 3'b101 && funct7 != 7'b0100000) begin
                        inst_class = class_illegal;
                    end
                end
                op_reg: begin
                    inst_class = class_r;
                    if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                        alu_op = alu_add;
                    end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                        alu_op = alu_sub;
                    end else begin
                        inst_class = class_illegal;
                    end
                end
                // auipc adds the pc, lui passes the immediate
                op_lui:   inst_class = class_u;
                op_auipc: begin
                    inst_class = class_u;
                    alu_op     = alu_add;
                end
                op_store: begin
                    // address is rs1 + imm
                    inst_class = (funct3[2] || funct3[1:0] == 2'b11) ? class_illegal : class_s;
                    alu_op     = alu_add;
                end
                default:  inst_class = class_illegal;
            endcase
        end
    end

    // system words keep funct12 so ebreak shows up as imm 1
    always_comb begin
        case (inst_class)
            class_i, class_n: imm = {{20{inst[31]}}, inst[31:20]};
            class_s:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            class_u:          imm = {inst[31:12], 12'b0};
            default:          imm = '0;
        endcase
    end

endmodule

// File: rv_regfile.sv
// ====================
// 32 x 32 register file
// two async reads, one write
// ====================

module rv_regfile import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rs1_data,
    output logic [xlen-1:0]       rs2_data
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads see every write from earlier edges
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// File: rv_exec.sv
// ====================
// execute stage: alu, pc, output credits
// halt state and retire record register
// ====================

module rv_exec import rv_core_pkg::*; #(
    parameter int res_credits = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  head_valid,
    input  inst_class_e           inst_class,
    input  alu_op_e               alu_op,
    input  logic [reg_addr_w-1:0] rd_addr,
    input  logic [xlen-1:0]       imm,
    input  logic [1:0]            store_size,
    input  logic [xlen-1:0]       rs1_data,
    input  logic [xlen-1:0]       rs2_data,
    input  logic                  res_credit,
    output logic                  pop,
    output logic                  we,
    output logic [reg_addr_w-1:0] waddr,
    output logic [xlen-1:0]       wdata,
    output logic                  res_valid,
    output retire_kind_e          res_kind,
    output logic [reg_addr_w-1:0] res_rd,
    output logic [xlen-1:0]       res_value,
    output logic [xlen-1:0]       res_store_data,
    output logic                  halted
);

    localparam int cred_w = $clog2(res_credits + 1);

    logic [cred_w-1:0] credit_cnt;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
    logic [xlen-1:0]   alu_res;
    logic [xlen-1:0]   st_data;
    retire_kind_e      kind;

    // issue when an instruction waits, a record slot is free and not halted
    assign pop = head_valid && (credit_cnt != '0) && !halted;

    // auipc takes the pc, register ops take rs2, others the immediate
    assign op_a = (inst_class == class_u) ? pc : rs1_data;
    assign op_b = (inst_class == class_r) ? rs2_data : imm;

    always_comb begin
        case (alu_op)
            alu_add:  alu_res = op_a + op_b;
            alu_sub:  alu_res = op_a - op_b;
            alu_sltu: alu_res = {{(xlen - 1){1'b0}}, op_a < op_b};
            // shamt in the low five bits
            alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
            alu_and:  alu_res = op_a & op_b;
            default:  alu_res = op_b;
        endcase
    end

    // store data trimmed to byte, half or word
    always_comb begin
        case (store_size)
            2'b00:   st_data = {{(xlen - 8){1'b0}}, rs2_data[7:0]};
            2'b01:   st_data = {{(xlen - 16){1'b0}}, rs2_data[15:0]};
            default: st_data = rs2_data;
        endcase
    end

    // ebreak carries funct12 = 1 in the immediate
    always_comb begin
        case (inst_class)
            class_i, class_u, class_r: kind = kind_reg;
            class_s:                   kind = kind_store;
            class_n:                   kind = imm[0] ? kind_halt : kind_ecall;
            default:                   kind = kind_illegal;
        endcase
    end

    // register write lands on the pop edge
    assign we    = pop && (kind == kind_reg);
    assign waddr = rd_addr;
    assign wdata = alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= cred_w'(res_credits);
            pc         <= '0;
            res_valid  <= 1'b0;
            halted     <= 1'b0;
        end else begin
            // one credit spent per pop, one back per consumer pulse
            case ({pop, res_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            if (pop) begin
                pc <= pc + 32'd4;
            end
            res_valid <= pop;
            // sticky until reset
            if (pop && kind == kind_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // record payload, qualified by res_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            res_kind       <= kind;
            res_rd         <= (kind == kind_reg) ? rd_addr : '0;
            res_value      <= (kind == kind_reg || kind == kind_store) ? alu_res : '0;
            res_store_data <= (kind == kind_store) ? st_data : '0;
        end
    end

endmodule

// File: rv_core_top.sv
// ====================
// core top: queue, decoder,
// register file, execute stage
// ====================

module rv_core_top import rv_core_pkg::*; #(
    parameter int inst_depth  = 4,
    parameter int res_credits = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  logic [xlen-1:0]       inst_data,
    input  logic                  res_credit,
    output logic                  inst_credit,
    output logic                  res_valid,
    output retire_kind_e          res_kind,
    output logic [reg_addr_w-1:0] res_rd,
    output logic [xlen-1:0]       res_value,
    output logic [xlen-1:0]       res_store_data,
    output logic                  halted
);

    // queue head
    logic                  head_valid;
    logic [xlen-1:0]       head_inst;
    logic                  pop;

    // decoded fields
    inst_class_e           inst_class;
    alu_op_e               alu_op;
    logic [reg_addr_w-1:0] rd_addr;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       imm;
    logic [1:0]            store_size;

    // register file traffic
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  we;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;

    rv_inst_queue #(
        .inst_depth (inst_depth)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (inst_valid),
        .push_data  (inst_data),
        .pop        (pop),
        .head_valid (head_valid),
        .head_inst  (head_inst),
        .credit     (inst_credit)
    );

    // decoder and register file both look at the queue head
    rv_decode u_decode (
        .inst       (head_inst),
        .inst_class (inst_class),
        .alu_op     (alu_op),
        .rd_addr    (rd_addr),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .imm        (imm),
        .store_size (store_size)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (we),
        .waddr    (waddr),
        .wdata    (wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_exec #(
        .res_credits (res_credits)
    ) u_exec (
        .clk            (clk),
        .rst_n          (rst_n),
        .head_valid     (head_valid),
        .inst_class     (inst_class),
        .alu_op         (alu_op),
        .rd_addr        (rd_addr),
        .imm            (imm),
        .store_size     (store_size),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .res_credit     (res_credit),
        .pop            (pop),
        .we             (we),
        .waddr          (waddr),
        .wdata          (wdata),
        .res_valid      (res_valid),
        .res_kind       (res_kind),
        .res_rd         (res_rd),
        .res_value      (res_value),
        .res_store_data (res_store_data),
        .halted         (halted)
    );

endmodule

// File: rv_core_chk.sv
// ====================
// credit and halt assertions
// bound into rv_exec
// ====================

module rv_core_chk import rv_core_pkg::*; #(
    parameter int res_credits = 2
) (
    input logic         clk,
    input logic         rst_n,
    input logic         pop,
    input logic         res_valid,
    input retire_kind_e res_kind,
    input logic         res_credit,
    input logic         halted
);

    // records issued and not yet paid back by the consumer
    int   owed;
    // halt record already out
    logic halt_seen;
    logic after_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed      <= 0;
            halt_seen <= 1'b0;
        end else begin
            owed <= owed + int'(pop) - int'(res_credit);
            if (res_valid && res_kind == kind_halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

    // from the halt record cycle on
    assign after_halt = halt_seen || (res_valid && res_kind == kind_halt);

    // every record was paid for on its issue cycle
    a_record_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> $past(owed) < res_credits)
    else $error("retire record issued with no output credit left");

    // queue stays frozen once halted
    a_no_pop_halted: assert property (@(posedge clk) disable iff (!rst_n)
        after_halt |-> !pop)
    else $error("pop raised after the halt record");

    // sticky until reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        after_halt |-> halted)
    else $error("halted low after the halt record");

endmodule

bind rv_exec rv_core_chk #(
    .res_credits (res_credits)
) u_core_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop        (pop),
    .res_valid  (res_valid),
    .res_kind   (res_kind),
    .res_credit (res_credit),
    .halted     (halted)
);

// File: tb_rv_core.sv
// ====================
// testbench for rv_core_top
// table-driven instruction stream, random credit timing
// in-order retire record checks, back-pressure and halt
// ====================

module tb_rv_core import rv_core_pkg::*; ();

    localparam int inst_depth  = 4;
    localparam int res_credits = 2;
    localparam int num_tests   = 25;
    localparam int row_words   = 6;
    // kind column value for words sent after the halt
    localparam int no_record   = 7;
    localparam int stall_row   = 4;
    localparam int stall_len   = 16;
    localparam int drain_len   = 20;
    localparam int max_cycles  = 20 * num_tests + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [xlen-1:0]       inst_data;
    logic                  res_credit;
    logic                  inst_credit;
    logic                  res_valid;
    retire_kind_e          res_kind;
    logic [reg_addr_w-1:0] res_rd;
    logic [xlen-1:0]       res_value;
    logic [xlen-1:0]       res_store_data;
    logic                  halted;

    // one row: test, inst, kind, rd, value, store data
    logic [31:0] tdata [num_tests * row_words];

    int errors;
    int test_errors;
    int recv_idx;
    int send_idx;
    int send_credits;
    // records taken but not yet paid back to the core
    int pending;
    int num_expected;
    int cycle;
    int drain;
    int stall_left;
    int stall_avail;
    int win_recs;
    int win_icreds;
    bit halt_done;
    bit late_activity;
    bit stall_started;
    bit finished;

    rv_core_top #(
        .inst_depth  (inst_depth),
        .res_credits (res_credits)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .res_credit     (res_credit),
        .inst_credit    (inst_credit),
        .res_valid      (res_valid),
        .res_kind       (res_kind),
        .res_rd         (res_rd),
        .res_value      (res_value),
        .res_store_data (res_store_data),
        .halted         (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_field(input int test_no, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] test_%0d %s: expected 0x%08h, actual 0x%08h",
                     test_no, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // compare the record at the outputs with the next expected row
    task automatic check_record();
        int base;
        int test_no;
        bit exp_halted;
        base        = recv_idx * row_words;
        test_no     = int'(tdata[base]);
        // halted rises together with the ebreak record
        exp_halted  = (tdata[base + 2] == kind_halt);
        test_errors = 0;
        compare_field(test_no, "kind", tdata[base + 2], {29'd0, res_kind});
        compare_field(test_no, "rd", tdata[base + 3], {27'd0, res_rd});
        compare_field(test_no, "value", tdata[base + 4], res_value);
        compare_field(test_no, "store data", tdata[base + 5], res_store_data);
        compare_field(test_no, "halted", {31'd0, exp_halted}, {31'd0, halted});
        if (test_errors == 0) begin
            $display("test_%0d passed", test_no);
        end else begin
            $display("test_%0d: %0d mismatches", test_no, test_errors);
        end
    endtask

    initial begin
        int unsigned seed_val;
        int          r;
        seed_val   = $urandom(32'h1884_4a11);
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst_data  = '0;
        res_credit = 1'b0;
        send_credits = inst_depth;
        $readmemh("rv_core_testdata.txt", tdata);
        for (r = 0; r < num_tests; r++) begin
            if (tdata[r * row_words] != r) begin
                $display("test data row %0d holds test number %0h", r, tdata[r * row_words]);
                errors++;
            end
            if (tdata[r * row_words + 2] != no_record) begin
                num_expected++;
            end
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // outputs sampled and inputs driven on the falling edge
        while (!finished && cycle < max_cycles) begin
            @(negedge clk);
            cycle++;
            if (halt_done && (res_valid || inst_credit || !halted)) begin
                $display("core misbehaved after halt: res_valid %0b, inst_credit %0b, halted %0b",
                         res_valid, inst_credit, halted);
                errors++;
                late_activity = 1'b1;
            end else begin
                if (inst_credit) begin
                    send_credits++;
                    if (send_credits > inst_depth) begin
                        $display("core returned more instruction credits than were sent");
                        errors++;
                    end
                end
                if (res_valid) begin
                    if (pending >= res_credits) begin
                        $display("retire record sent while the core held no output credit");
                        errors++;
                    end
                    pending++;
                    if (recv_idx >= num_expected) begin
                        $display("unexpected retire record of kind %0d", res_kind);
                        errors++;
                    end else begin
                        check_record();
                        recv_idx++;
                    end
                    if (res_kind == kind_halt) begin
                        halt_done = 1'b1;
                    end
                end
            end

            // back-pressure window, no credits go back to the core
            if (stall_left > 0) begin
                win_recs   += int'(res_valid);
                win_icreds += int'(inst_credit);
                stall_left--;
                if (stall_left == 0) begin
                    $display("back-pressure: %0d records, %0d inst credits, %0d credits held",
                             win_recs, win_icreds, stall_avail);
                    if (win_recs > stall_avail || win_icreds > stall_avail) begin
                        $display("core kept retiring after its output credits ran out");
                        errors++;
                    end
                end
            end
            if (!stall_started && send_idx >= stall_row) begin
                stall_started = 1'b1;
                stall_left    = stall_len;
                stall_avail   = res_credits - pending;
            end

            inst_valid = 1'b0;
            res_credit = 1'b0;
            if (send_idx < num_tests && send_credits > 0 && ($urandom % 4) != 0) begin
                inst_valid = 1'b1;
                inst_data  = tdata[send_idx * row_words + 1];
                send_credits--;
                send_idx++;
            end
            if (stall_left == 0 && pending > 0 && ($urandom % 3) != 0) begin
                res_credit = 1'b1;
                pending--;
            end

            // quiet period after the last record, catches late activity
            if (recv_idx >= num_expected && send_idx == num_tests) begin
                drain++;
                finished = (drain >= drain_len);
            end
        end

        if (finished) begin
            for (r = num_expected; r < num_tests; r++) begin
                if (late_activity) begin
                    $display("test_%0d sent after halt, core kept running", r);
                end else begin
                    $display("test_%0d sent after halt, no record and no credit seen", r);
                end
            end
        end else begin
            $display("timeout after %0d cycles, %0d of %0d records seen",
                     cycle, recv_idx, num_expected);
            errors++;
        end
        $display("summary: %0d records checked, %0d errors", recv_idx, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rv_core_testdata.txt
// test  inst      kind rd value    store_data   (all hex)
// kind 0 reg, 1 store, 2 ecall, 3 halt, 4 illegal, 7 no record expected
// immediate and register arithmetic
00 00500093 0 01 00000005 00000000
01 ffd00113 0 02 fffffffd 00000000
02 002081b3 0 03 00000002 00000000
03 40208233 0 04 00000008 00000000
04 00713293 0 05 00000000 00000000
05 fff0b313 0 06 00000001 00000000
06 40115393 0 07 fffffffe 00000000
07 0f017413 0 08 000000f0 00000000
// write to x0, then read x0 back
08 00908013 0 00 0000000e 00000000
09 001004b3 0 09 00000005 00000000
// lui and auipc, pc is 4 per instruction
0a 12345537 0 0a 12345000 00000000
0b 00001597 0 0b 0000102c 00000000
// sw, sh, sb
0c 00a0a423 1 00 0000000d 12345000
0d fe219f23 1 00 00000000 0000fffd
0e 00748823 1 00 00000015 000000fe
// ecall, custom opcode, load, then x1 read back
0f 00000073 2 00 00000000 00000000
10 0000008b 4 00 00000000 00000000
11 00002083 4 00 00000000 00000000
12 00008633 0 0c 00000005 00000000
13 7ff00713 0 0e 000007ff 00000000
14 40e007b3 0 0f fffff801 00000000
15 fffff817 0 10 fffff054 00000000
// ebreak, then words that must not retire
16 00100073 3 00 00000000 00000000
17 00100093 7 00 00000000 00000000
18 001088b3 7 00 00000000 00000000

// File: rv_core.f
rv_core_pkg.sv
rv_inst_queue.sv
rv_decode.sv
rv_regfile.sv
rv_exec.sv
rv_core_top.sv
rv_core_chk.sv
tb_rv_core.sv

// File: Makefile
# Verilator build and run for the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log gets the simulator exit status on its last line
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; echo "exit $$?" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "^exit 0$$" $(LOG); then echo "simulation aborted"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
